/* mips_wb_consts.svh */
`ifndef MIPS_WB_CONSTS_SVH
`define MIPS_WB_CONSTS_SVH

// Datapath widths.
`define MIPS_NBITS      32
`define MIPS_RNBITS     5

// Data memory depth in words.
`define MIPS_DMEM_WORDS 64

// Access size codes, shared by loads and stores.
`define MIPS_LD_BYTE    2'd0
`define MIPS_LD_HALF    2'd1
`define MIPS_LD_WORD    2'd3

`endif

/* mips_wb_pkg.sv */
`include "mips_wb_consts.svh"

package mips_wb_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath types
    ////////////////////////////////////////////////////////////

    typedef logic [`MIPS_NBITS-1:0]  word_t;      // Data word.
    typedef logic [`MIPS_RNBITS-1:0] reg_addr_t;  // Register number.

    // Load or store size code.
    typedef logic [1:0] ld_size_t;

    ////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////

    // Word index into the data memory.
    typedef logic [$clog2(`MIPS_DMEM_WORDS)-1:0] dmem_addr_t;

endpackage

/* mem_stage.sv */
`timescale 1ns/100ps
`include "mips_wb_consts.svh"

module mem_stage
(
    input  logic                  i_clk,
    input  logic                  i_mem_write,
    input  mips_wb_pkg::ld_size_t i_size,
    input  mips_wb_pkg::word_t    i_alu,
    input  mips_wb_pkg::word_t    i_store_data,
    output mips_wb_pkg::word_t    o_mem_word
);

    import mips_wb_pkg::*;

    word_t      mem [0:`MIPS_DMEM_WORDS-1];
    dmem_addr_t word_addr;
    logic [3:0] lane_en;     // One bit per byte lane.
    word_t      lane_data;

    // Byte address to word index.
    assign word_addr = i_alu[$bits(dmem_addr_t)+1:2];

    ////////////////////////////////////////////////////////////
    // Store lane select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (i_size)
            `MIPS_LD_BYTE:
            begin
                lane_en   = 4'b0001 << i_alu[1:0];
                lane_data = {4{i_store_data[7:0]}};     // Byte copied to every lane.
            end
            `MIPS_LD_HALF:
            begin
                lane_en   = i_alu[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_store_data[15:0]}};
            end
            default:
            begin
                lane_en   = 4'b1111;                    // Full word.
                lane_data = i_store_data;
            end
        endcase
    end

    // Stores land at the rising edge.
    always_ff @(posedge i_clk)
    begin
        if (i_mem_write)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (lane_en[b])
                    mem[word_addr][8*b +: 8] <= lane_data[8*b +: 8];
            end
        end
    end

    // Old contents until the edge.
    assign o_mem_word = mem[word_addr];

endmodule

/* mem_wb_reg.sv */
`timescale 1ns/100ps

module mem_wb_reg
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  mips_wb_pkg::word_t     i_pc4,
    input  mips_wb_pkg::word_t     i_alu,
    input  mips_wb_pkg::word_t     i_mem_word,
    input  mips_wb_pkg::word_t     i_ext,
    input  mips_wb_pkg::reg_addr_t i_rd,
    input  logic                   i_mem_to_reg,
    input  logic                   i_reg_write,
    input  mips_wb_pkg::ld_size_t  i_size,
    input  logic                   i_zero_extend,
    input  logic                   i_link,
    input  logic                   i_lui,
    output mips_wb_pkg::word_t     o_pc4,
    output mips_wb_pkg::word_t     o_alu,
    output mips_wb_pkg::word_t     o_mem_word,
    output mips_wb_pkg::word_t     o_ext,
    output mips_wb_pkg::reg_addr_t o_rd,
    output logic                   o_mem_to_reg,
    output logic                   o_reg_write,
    output mips_wb_pkg::ld_size_t  o_size,
    output logic                   o_zero_extend,
    output logic                   o_link,
    output logic                   o_lui
);

    import mips_wb_pkg::*;

    // Payload fields.
    always_ff @(posedge i_clk)
    begin
        o_pc4      <= i_pc4;
        o_alu      <= i_alu;
        o_mem_word <= i_mem_word;
        o_ext      <= i_ext;
        o_rd       <= i_rd;
    end

    // WB control bits.
    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            o_mem_to_reg  <= 1'b0;
            o_reg_write   <= 1'b0;
            o_size        <= ld_size_t'(`MIPS_LD_WORD);
            o_zero_extend <= 1'b0;
            o_link        <= 1'b0;
            o_lui         <= 1'b0;
        end
        else
        begin
            o_mem_to_reg  <= i_mem_to_reg;
            o_reg_write   <= i_reg_write;
            o_size        <= i_size;
            o_zero_extend <= i_zero_extend;
            o_link        <= i_link;
            o_lui         <= i_lui;
        end
    end

endmodule

/* wb_stage.sv */
`timescale 1ns/100ps
`include "mips_wb_consts.svh"

module wb_stage
(
    input  mips_wb_pkg::word_t     i_pc4,
    input  mips_wb_pkg::word_t     i_alu,
    input  mips_wb_pkg::word_t     i_mem_word,
    input  mips_wb_pkg::word_t     i_ext,
    input  mips_wb_pkg::reg_addr_t i_rd,
    input  logic                   i_mem_to_reg,
    input  logic                   i_reg_write,
    input  mips_wb_pkg::ld_size_t  i_size,
    input  logic                   i_zero_extend,
    input  logic                   i_link,
    input  logic                   i_lui,
    output logic                   o_we,
    output mips_wb_pkg::reg_addr_t o_waddr,
    output mips_wb_pkg::word_t     o_wdata
);

    import mips_wb_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       ld_value;      // Filtered load.

    ////////////////////////////////////////////////////////////
    // Load filter
    ////////////////////////////////////////////////////////////

    // Little-endian lane pick.
    assign ld_byte = i_mem_word[8*i_alu[1:0] +: 8];
    assign ld_half = i_mem_word[16*i_alu[1] +: 16];

    always_comb
    begin
        case (i_size)
            `MIPS_LD_BYTE:
            begin
                if (i_zero_extend)
                    ld_value = {{(`MIPS_NBITS-8){1'b0}}, ld_byte};
                else
                    ld_value = {{(`MIPS_NBITS-8){ld_byte[7]}}, ld_byte};
            end
            `MIPS_LD_HALF:
            begin
                if (i_zero_extend)
                    ld_value = {{(`MIPS_NBITS-16){1'b0}}, ld_half};
                else
                    ld_value = {{(`MIPS_NBITS-16){ld_half[15]}}, ld_half};
            end
            default:
                ld_value = i_mem_word;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Source select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        if (i_lui)
            o_wdata = {i_ext[15:0], 16'h0000};      // Upper immediate.
        else if (i_link)
            o_wdata = i_pc4;
        else if (i_mem_to_reg)
            o_wdata = ld_value;
        else
            o_wdata = i_alu;
    end

    // No writes to register 0.
    assign o_we    = i_reg_write && (i_rd != '0);
    assign o_waddr = i_rd;

endmodule

/* reg_file.sv */
`timescale 1ns/100ps
`include "mips_wb_consts.svh"

module reg_file
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_we,
    input  mips_wb_pkg::reg_addr_t i_waddr,
    input  mips_wb_pkg::word_t     i_wdata,
    input  mips_wb_pkg::reg_addr_t i_raddr,
    output mips_wb_pkg::word_t     o_rdata
);

    import mips_wb_pkg::*;

    localparam int NREGS = 2 ** `MIPS_RNBITS;

    word_t regs [0:NREGS-1];

    always_ff @(posedge i_clk)
    begin
        if (!i_rst_n)
        begin
            for (int r = 0; r < NREGS; r++)
                regs[r] <= '0;
        end
        else if (i_we && (i_waddr != '0))
        begin
            regs[i_waddr] <= i_wdata;           // Register 0 stays zero.
        end
    end

    // Combinational read.
    assign o_rdata = (i_raddr == '0) ? '0 : regs[i_raddr];

endmodule

/* mips_wb_top.sv */
`timescale 1ns/100ps

module mips_wb_top
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  mips_wb_pkg::word_t     i_pc4,
    input  mips_wb_pkg::word_t     i_alu,
    input  mips_wb_pkg::word_t     i_store_data,
    input  mips_wb_pkg::word_t     i_ext,
    input  mips_wb_pkg::reg_addr_t i_rd,
    input  logic                   i_mem_write,
    input  logic                   i_mem_to_reg,
    input  logic                   i_reg_write,
    input  mips_wb_pkg::ld_size_t  i_size,
    input  logic                   i_zero_extend,
    input  logic                   i_link,
    input  logic                   i_lui,
    input  mips_wb_pkg::reg_addr_t i_rd_addr,
    output mips_wb_pkg::word_t     o_rd_data,
    output logic                   o_wb_we,
    output mips_wb_pkg::reg_addr_t o_wb_addr,
    output mips_wb_pkg::word_t     o_wb_data
);

    import mips_wb_pkg::*;

    word_t     mem_word;        // Raw load word, MEM side.

    // MEM/WB register outputs.
    word_t     wb_pc4;
    word_t     wb_alu;
    word_t     wb_mem_word;
    word_t     wb_ext;
    reg_addr_t wb_rd;
    logic      wb_mem_to_reg;
    logic      wb_reg_write;
    ld_size_t  wb_size;
    logic      wb_zero_extend;
    logic      wb_link;
    logic      wb_lui;

    ////////////////////////////////////////////////////////////
    // Memory stage and pipeline register
    ////////////////////////////////////////////////////////////

    mem_stage u_mem_stage
    (
        .i_clk        (i_clk),
        .i_mem_write  (i_mem_write),
        .i_size       (i_size),
        .i_alu        (i_alu),
        .i_store_data (i_store_data),
        .o_mem_word   (mem_word)
    );

    mem_wb_reg u_mem_wb_reg
    (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pc4         (i_pc4),
        .i_alu         (i_alu),
        .i_mem_word    (mem_word),
        .i_ext         (i_ext),
        .i_rd          (i_rd),
        .i_mem_to_reg  (i_mem_to_reg),
        .i_reg_write   (i_reg_write),
        .i_size        (i_size),
        .i_zero_extend (i_zero_extend),
        .i_link        (i_link),
        .i_lui         (i_lui),
        .o_pc4         (wb_pc4),
        .o_alu         (wb_alu),
        .o_mem_word    (wb_mem_word),
        .o_ext         (wb_ext),
        .o_rd          (wb_rd),
        .o_mem_to_reg  (wb_mem_to_reg),
        .o_reg_write   (wb_reg_write),
        .o_size        (wb_size),
        .o_zero_extend (wb_zero_extend),
        .o_link        (wb_link),
        .o_lui         (wb_lui)
    );

    ////////////////////////////////////////////////////////////
    // Writeback and register file
    ////////////////////////////////////////////////////////////

    wb_stage u_wb_stage
    (
        .i_pc4         (wb_pc4),
        .i_alu         (wb_alu),
        .i_mem_word    (wb_mem_word),
        .i_ext         (wb_ext),
        .i_rd          (wb_rd),
        .i_mem_to_reg  (wb_mem_to_reg),
        .i_reg_write   (wb_reg_write),
        .i_size        (wb_size),
        .i_zero_extend (wb_zero_extend),
        .i_link        (wb_link),
        .i_lui         (wb_lui),
        .o_we          (o_wb_we),
        .o_waddr       (o_wb_addr),
        .o_wdata       (o_wb_data)
    );

    reg_file u_reg_file
    (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_we    (o_wb_we),
        .i_waddr (o_wb_addr),
        .i_wdata (o_wb_data),
        .i_raddr (i_rd_addr),
        .o_rdata (o_rd_data)
    );

endmodule

/* mips_wb_props.sv */
`timescale 1ns/100ps

module mips_wb_props
(
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_wb_we,
    input  mips_wb_pkg::reg_addr_t i_wb_addr,
    input  mips_wb_pkg::word_t     i_wb_data
);

    int fail_count = 0;

    // Control bits come out of reset cleared.
    a_idle_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> !i_wb_we)
    else
    begin
        fail_count++;
        $error("o_wb_we set in the first cycle after reset");
    end

    a_no_reg0_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                      !(i_wb_we && (i_wb_addr == '0)))
    else
    begin
        fail_count++;
        $error("Writeback to register 0 enabled");
    end

    a_data_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
                                   i_wb_we |-> !$isunknown(i_wb_data))
    else
    begin
        fail_count++;
        $error("Unknown writeback data with o_wb_we set");
    end

endmodule

bind mips_wb_top mips_wb_props u_props
(
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_wb_we   (o_wb_we),
    .i_wb_addr (o_wb_addr),
    .i_wb_data (o_wb_data)
);

/* mips_wb_tb.sv */
`timescale 1ns/100ps
`include "mips_wb_consts.svh"

module mips_wb_tb;

    import mips_wb_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int DRAIN_LIMIT = 20;     // Cycles allowed for the final drain.

    typedef struct packed
    {
        word_t     pc4;
        word_t     alu;
        word_t     store_data;
        word_t     ext;
        reg_addr_t rd;
        logic      mem_write;
        logic      mem_to_reg;
        logic      reg_write;
        ld_size_t  size;
        logic      zero_extend;
        logic      link;
        logic      lui;
    } op_t;

    logic      i_clk;
    logic      i_rst_n;
    word_t     i_pc4;
    word_t     i_alu;
    word_t     i_store_data;
    word_t     i_ext;
    reg_addr_t i_rd;
    logic      i_mem_write;
    logic      i_mem_to_reg;
    logic      i_reg_write;
    ld_size_t  i_size;
    logic      i_zero_extend;
    logic      i_link;
    logic      i_lui;
    reg_addr_t i_rd_addr;
    word_t     o_rd_data;
    logic      o_wb_we;
    reg_addr_t o_wb_addr;
    word_t     o_wb_data;

    op_t       ops [$];
    op_t       idle;
    op_t       rst_op;                              // Live write held during reset.
    word_t     model_mem [0:`MIPS_DMEM_WORDS-1];   // Unwritten words stay X.
    word_t     model_regs [0:31];
    logic      exp_we_q [$];
    reg_addr_t exp_addr_q [$];
    word_t     exp_data_q [$];
    int        errors;
    int        cycles;

    mips_wb_top UUT (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    ////////////////////////////////////////////////////////////
    // Pattern file and reference model
    ////////////////////////////////////////////////////////////

    task automatic load_patterns();
        int    fd;
        int    n;
        string line;
        word_t fld [0:11];
        op_t   op;
        fd = $fopen("mips_wb_patterns.txt", "r");
        if (fd == 0)
        begin
            errors++;
            $display("Could not open the pattern file mips_wb_patterns.txt");
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 2 || line.getc(0) == "#")
                continue;                                   // Comment or blank.
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                        fld[6], fld[7], fld[8], fld[9], fld[10], fld[11]);
            if (n != 12)
            begin
                errors++;
                $display("Pattern line has %0d fields instead of 12: %s", n, line);
                continue;
            end
            op.pc4         = fld[0];
            op.alu         = fld[1];
            op.store_data  = fld[2];
            op.ext         = fld[3];
            op.rd          = fld[4][4:0];
            op.mem_write   = fld[5][0];
            op.mem_to_reg  = fld[6][0];
            op.reg_write   = fld[7][0];
            op.size        = fld[8][1:0];
            op.zero_extend = fld[9][0];
            op.link        = fld[10][0];
            op.lui         = fld[11][0];
            ops.push_back(op);
        end
        $fclose(fd);
        if (ops.size() == 0)
        begin
            errors++;
            $display("The pattern file holds no operations");
        end
    endtask

    // Size and extension applied to a raw memory word.
    function automatic word_t filter_load(word_t w, logic [1:0] off, ld_size_t size,
                                          logic zext);
        logic [4:0] lsb;
        word_t      shifted;
        lsb     = (size == `MIPS_LD_HALF) ? {off[1], 4'b0000} : {off, 3'b000};
        shifted = w >> lsb;
        if (size == `MIPS_LD_BYTE)
            filter_load = zext ? {24'h0, shifted[7:0]} : {{24{shifted[7]}}, shifted[7:0]};
        else if (size == `MIPS_LD_HALF)
            filter_load = zext ? {16'h0, shifted[15:0]} : {{16{shifted[15]}}, shifted[15:0]};
        else
            filter_load = w;
    endfunction

    task automatic drive_inputs(op_t op);
        i_pc4         = op.pc4;
        i_alu         = op.alu;
        i_store_data  = op.store_data;
        i_ext         = op.ext;
        i_rd          = op.rd;
        i_mem_write   = op.mem_write;
        i_mem_to_reg  = op.mem_to_reg;
        i_reg_write   = op.reg_write;
        i_size        = op.size;
        i_zero_extend = op.zero_extend;
        i_link        = op.link;
        i_lui         = op.lui;
    endtask

    // Expected writeback first, then the store.
    task automatic apply_op(op_t op);
        dmem_addr_t idx;
        word_t      data;
        logic       we;
        idx = op.alu[$bits(dmem_addr_t)+1:2];
        if (op.lui)
            data = op.ext << 16;
        else if (op.link)
            data = op.pc4;
        else if (op.mem_to_reg)
            data = filter_load(model_mem[idx], op.alu[1:0], op.size, op.zero_extend);
        else
            data = op.alu;
        we = op.reg_write && (op.rd != 5'd0);
        exp_we_q.push_back(we);
        exp_addr_q.push_back(op.rd);
        exp_data_q.push_back(data);
        if (we)
            model_regs[op.rd] = data;
        if (op.mem_write)
        begin
            if (op.size == `MIPS_LD_BYTE)
                model_mem[idx][8*op.alu[1:0] +: 8] = op.store_data[7:0];
            else if (op.size == `MIPS_LD_HALF)
                model_mem[idx][16*op.alu[1] +: 16] = op.store_data[15:0];
            else
                model_mem[idx] = op.store_data;
        end
        drive_inputs(op);
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    task automatic check_writeback();
        logic      e_we;
        reg_addr_t e_addr;
        word_t     e_data;
        if (exp_we_q.size() == 0)
            return;
        e_we   = exp_we_q.pop_front();
        e_addr = exp_addr_q.pop_front();
        e_data = exp_data_q.pop_front();
        assert (o_wb_we === e_we)
        else
        begin
            errors++;
            $display("CHECK FAILED o_wb_we expected %h got %h", e_we, o_wb_we);
        end
        assert (o_wb_addr === e_addr)
        else
        begin
            errors++;
            $display("CHECK FAILED o_wb_addr expected %h got %h", e_addr, o_wb_addr);
        end
        assert (o_wb_data === e_data)
        else
        begin
            errors++;
            $display("CHECK FAILED o_wb_data expected %h got %h", e_data, o_wb_data);
        end
    endtask

    // Address set on one falling edge, data checked on the next.
    task automatic sweep_regs();
        for (int r = 0; r <= 32; r++)
        begin
            @(negedge i_clk);
            if (r > 0)
            begin
                assert (o_rd_data === model_regs[r-1])
                else
                begin
                    errors++;
                    $display("CHECK FAILED o_rd_data (reg %0d) expected %h got %h",
                             r - 1, model_regs[r-1], o_rd_data);
                end
            end
            if (r < 32)
                i_rd_addr = reg_addr_t'(r);
        end
    endtask

    initial
    begin
        errors           = 0;
        idle             = '0;
        rst_op           = '0;
        rst_op.alu       = 32'h0bad0bad;
        rst_op.rd        = 5'd1;
        rst_op.reg_write = 1'b1;
        i_rst_n          = 1'b0;
        i_rd_addr        = '0;
        drive_inputs(rst_op);
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        load_patterns();

        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;
        drive_inputs(idle);
        assert (o_wb_we === 1'b0)
        else
        begin
            errors++;
            $display("CHECK FAILED o_wb_we expected 0 got %h after reset", o_wb_we);
        end
        sweep_regs();

        foreach (ops[i])
        begin
            @(negedge i_clk);
            check_writeback();
            apply_op(ops[i]);
        end

        cycles = 0;
        while (exp_we_q.size() != 0 && cycles < DRAIN_LIMIT)
        begin
            @(negedge i_clk);
            check_writeback();
            drive_inputs(idle);
            cycles++;
        end
        if (exp_we_q.size() != 0)
        begin
            errors++;
            $display("Pipeline did not drain within %0d cycles", DRAIN_LIMIT);
        end
        sweep_regs();

        errors += UUT.u_props.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* mips_wb_patterns.txt */
# pc4 alu store_data ext rd mem_write mem_to_reg reg_write size zero_extend link lui
# All fields in hex; size 0 is byte, 1 is half-word, 3 is word.
00000004 12345678 00000000 00000000 01 0 0 1 3 0 0 0
00000008 deadbeef 00000000 00000000 00 0 0 1 3 0 0 0
0000000c 00000010 a1b2c3d4 00000000 00 1 0 0 3 0 0 0
00000010 00000010 00000000 00000000 03 0 1 1 3 0 0 0
00000014 00000020 00000000 00000000 00 1 0 0 3 0 0 0
00000018 00000020 11111181 00000000 00 1 0 0 0 0 0 0
0000001c 00000021 000000f2 00000000 00 1 0 0 0 0 0 0
00000020 00000022 00000033 00000000 00 1 0 0 0 0 0 0
00000024 00000023 000000c4 00000000 00 1 0 0 0 0 0 0
00000028 00000020 00000000 00000000 04 0 1 1 0 0 0 0
0000002c 00000021 00000000 00000000 05 0 1 1 0 1 0 0
00000030 00000022 00000000 00000000 06 0 1 1 0 0 0 0
00000034 00000023 00000000 00000000 08 0 1 1 0 0 0 0
00000038 00000012 00009876 00000000 00 1 0 0 1 0 0 0
0000003c 00000010 00008001 00000000 00 1 0 0 1 0 0 0
00000040 00000010 00000000 00000000 09 0 1 1 1 0 0 0
00000044 00000012 00000000 00000000 0a 0 1 1 1 1 0 0
00000048 00000020 55667788 00000000 07 1 1 1 3 0 0 0
0000004c 00000020 00000000 00000000 0c 0 1 1 3 0 0 0
00400020 00000000 00000000 00000000 1f 0 0 1 3 0 1 0
00000054 00000000 00000000 0000abcd 0d 0 0 1 3 0 0 1
00000058 00000020 00000000 ffff1234 0e 0 1 1 3 0 1 1
00400030 00000010 00000000 00000000 0f 0 1 1 3 0 1 0
00000060 11111111 00000000 00000000 01 0 0 1 3 0 0 0
00000064 22222222 00000000 00000000 01 0 0 1 3 0 0 0
00000068 33333333 00000000 00000000 02 0 0 1 3 0 0 0

/* mips_wb.f */
+incdir+.
mips_wb_pkg.sv
mem_stage.sv
mem_wb_reg.sv
wb_stage.sv
reg_file.sv
mips_wb_top.sv
mips_wb_props.sv
mips_wb_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --timing --assert --top-module mips_wb_tb -f mips_wb.f -o mips_wb_sim \
    && ./obj_dir/mips_wb_sim | tee /dev/stderr | grep -qx "Test OK" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
